// ==== common/rv_isa_pkg.sv ====
/*
 * RV32I instruction-set types: data and address words, major opcodes,
 * ALU operations, load and store codes, and the fetch address after reset.
 */
package rv_isa_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [4:0]      reg_addr_t;

	localparam addr_t RESET_PC = 32'h0000_0000;

	// major opcodes, instr[6:0].
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		PASS_B // operand b straight through, for LUI.
	} alu_op_e;

	typedef enum logic [2:0] {
		L_NONE, LB, LH, LW, LBU, LHU
	} load_code_e;

	typedef enum logic [1:0] {
		S_NONE, SB, SH, SW
	} store_code_e;

endpackage

// ==== common/pipe_ctrl_pkg.sv ====
/*
 * Pipeline-control types: hold codes and jump flags.
 */
package pipe_ctrl_pkg;

	// fetch stays enabled for every code below HOLD_IF.
	typedef enum logic [1:0] {
		HOLD_NONE = 2'd0,
		HOLD_IF   = 2'd1
	} hold_code_e;

	typedef enum logic [3:0] {
		J_NONE, J_JAL, J_JALR,
		J_BEQ, J_BNE, J_BLT, J_BGE, J_BLTU, J_BGEU
	} jmp_flag_e;

endpackage

// ==== rtl/pc.sv ====
/* Program counter with hold and jump load, and the fetch enable. */
`timescale 1ns/1ps

module pc (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  pipe_ctrl_pkg::hold_code_e hold_code_i,
	input  logic                      jmp_en_i,
	input  rv_isa_pkg::addr_t         jmp_to_i,
	output rv_isa_pkg::addr_t         pc_o,
	output logic                      instr_rd_en_o
);
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;

	addr_t pc_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= RESET_PC;
		end else if (jmp_en_i) begin
			pc_q <= jmp_to_i;
		end else if (hold_code_i != HOLD_IF) begin
			pc_q <= pc_q + 32'd4;
		end // under a hold the same address is fetched again.
	end

	assign pc_o          = pc_q;
	assign instr_rd_en_o = hold_code_i < HOLD_IF;

	// jump targets come from ctrl, so a misaligned JALR target shows up here.
	a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
		pc_o[1:0] == 2'b00);

endmodule

// ==== rtl/regs.sv ====
/* General register file, 32 x 32, two read ports and one write port. */
`timescale 1ns/1ps

module regs (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 wr_en_i,
	input  rv_isa_pkg::reg_addr_t addr_wr_i,
	input  rv_isa_pkg::reg_addr_t addr_rd1_i,
	input  rv_isa_pkg::reg_addr_t addr_rd2_i,
	input  rv_isa_pkg::data_t     data_wr_i,
	output rv_isa_pkg::data_t     data_rd1_o,
	output rv_isa_pkg::data_t     data_rd2_o
);
	import rv_isa_pkg::*;

	data_t rf_q [32];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				rf_q[i] <= '0;
			end
		end else if (wr_en_i && addr_wr_i != '0) begin
			rf_q[addr_wr_i] <= data_wr_i;
		end
	end

	// no write-through here, id_stage covers the same-cycle case.
	assign data_rd1_o = (addr_rd1_i == '0) ? '0 : rf_q[addr_rd1_i];
	assign data_rd2_o = (addr_rd2_i == '0) ? '0 : rf_q[addr_rd2_i];

	// NOPs write x0 all the time and its entry must stay zero.
	a_x0_discarded: assert property (@(posedge clk) disable iff (!arst_n_i)
		(wr_en_i && addr_wr_i == '0) |=> rf_q[0] == '0);

endmodule

// ==== rtl/ctrl.sv ====
/* Branch resolution, jump target and hold-code generation. */
`timescale 1ns/1ps

module ctrl (
	input  pipe_ctrl_pkg::jmp_flag_e  jmp_flag_i,
	input  rv_isa_pkg::data_t         jmp_rs1_i,
	input  rv_isa_pkg::data_t         jmp_rs2_i,
	input  rv_isa_pkg::addr_t         jmp_base_i,
	input  rv_isa_pkg::data_t         jmp_offset_i,
	input  logic                      load_hazard_i,
	output logic                      jmp_en_o,
	output rv_isa_pkg::addr_t         jmp_to_o,
	output pipe_ctrl_pkg::hold_code_e hold_code_o
);
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;

	logic  take;
	addr_t target;

	always_comb begin
		case (jmp_flag_i)
			J_JAL, J_JALR: take = 1'b1;
			J_BEQ:  take = jmp_rs1_i == jmp_rs2_i;
			J_BNE:  take = jmp_rs1_i != jmp_rs2_i;
			J_BLT:  take = $signed(jmp_rs1_i) < $signed(jmp_rs2_i);
			J_BGE:  take = $signed(jmp_rs1_i) >= $signed(jmp_rs2_i);
			J_BLTU: take = jmp_rs1_i < jmp_rs2_i;
			J_BGEU: take = jmp_rs1_i >= jmp_rs2_i;
			default: take = 1'b0;
		endcase
	end

	assign target   = jmp_base_i + jmp_offset_i;
	assign jmp_to_o = (jmp_flag_i == J_JALR) ? {target[31:1], 1'b0} : target;
	assign jmp_en_o = take;

	// the instruction in decode is flushed on a jump, so its hazard does not count.
	assign hold_code_o = (load_hazard_i && !take) ? HOLD_IF : HOLD_NONE;

endmodule

// ==== id_stage/id_stage.sv ====
/*
 * Decode stage: instruction decode, immediates, operand read with ALU bypass,
 * load-use detection and the ID/EX pipeline register.
 */
`timescale 1ns/1ps

module id_stage (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  pipe_ctrl_pkg::hold_code_e  hold_code_i,
	input  logic                       jmp_en_i,
	input  rv_isa_pkg::data_t          instr_i,
	input  rv_isa_pkg::addr_t          pc_i,
	input  rv_isa_pkg::data_t          data_rs1_i,
	input  rv_isa_pkg::data_t          data_rs2_i,
	input  logic                       ex_wr_en_i,
	input  rv_isa_pkg::reg_addr_t      ex_addr_wr_i,
	input  logic                       ex_is_load_i,
	input  rv_isa_pkg::data_t          ex_alu_result_i,
	output rv_isa_pkg::reg_addr_t      addr_rs1_o,
	output rv_isa_pkg::reg_addr_t      addr_rs2_o,
	output rv_isa_pkg::reg_addr_t      addr_wr_o,
	output logic                       reg_wr_en_o,
	output rv_isa_pkg::load_code_e     load_code_o,
	output rv_isa_pkg::store_code_e    store_code_o,
	output rv_isa_pkg::alu_op_e        alu_operation_o,
	output rv_isa_pkg::data_t          alu_op_num1_o,
	output rv_isa_pkg::data_t          alu_op_num2_o,
	output rv_isa_pkg::data_t          store_data_o,
	output pipe_ctrl_pkg::jmp_flag_e   jmp_flag_o,
	output rv_isa_pkg::data_t          jmp_rs1_o,
	output rv_isa_pkg::data_t          jmp_rs2_o,
	output rv_isa_pkg::addr_t          jmp_base_o,
	output rv_isa_pkg::data_t          jmp_offset_o,
	output logic                       load_hazard_o
);
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;

	opcode_e     opcode;
	logic [2:0]  funct3;
	data_t       imm_i, imm_s, imm_b, imm_u, imm_j;
	data_t       rs1_val, rs2_val;
	logic        hit1, hit2, use_rs1, use_rs2, issue;
	logic        dec_wr_en;
	load_code_e  dec_load;
	store_code_e dec_store;
	alu_op_e     dec_alu;
	jmp_flag_e   dec_jmp;
	data_t       dec_num1, dec_num2, dec_base, dec_offset;

	function automatic alu_op_e alu_decode(logic [2:0] f3, logic alt, logic is_reg);
		case (f3)
			3'b000: return (is_reg && alt) ? SUB : ADD;
			3'b001: return SLL;
			3'b010: return SLT;
			3'b011: return SLTU;
			3'b100: return XOR;
			3'b101: return alt ? SRA : SRL;
			3'b110: return OR;
			default: return AND;
		endcase
	endfunction

	assign opcode     = opcode_e'(instr_i[6:0]);
	assign funct3     = instr_i[14:12];
	assign addr_rs1_o = instr_i[19:15];
	assign addr_rs2_o = instr_i[24:20];

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// execute writes at the end of this cycle, regs has not seen it yet.
	assign hit1 = ex_wr_en_i && ex_addr_wr_i != '0 && ex_addr_wr_i == addr_rs1_o;
	assign hit2 = ex_wr_en_i && ex_addr_wr_i != '0 && ex_addr_wr_i == addr_rs2_o;
	assign rs1_val = (hit1 && !ex_is_load_i) ? ex_alu_result_i : data_rs1_i;
	assign rs2_val = (hit2 && !ex_is_load_i) ? ex_alu_result_i : data_rs2_i;
	assign load_hazard_o = ex_is_load_i && ((hit1 && use_rs1) || (hit2 && use_rs2));

	always_comb begin
		dec_wr_en = 1'b0;
		dec_load = L_NONE;
		dec_store = S_NONE;
		dec_jmp = J_NONE;
		dec_alu = ADD;
		dec_num1 = rs1_val;
		dec_num2 = rs2_val;
		dec_base = pc_i;
		dec_offset = imm_b;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			LUI: begin
				dec_wr_en = 1'b1;
				dec_alu = PASS_B;
				dec_num2 = imm_u;
			end
			AUIPC: begin
				dec_wr_en = 1'b1;
				dec_num1 = pc_i;
				dec_num2 = imm_u;
			end
			JAL, JALR: begin // the ALU forms the link address.
				dec_wr_en = 1'b1;
				dec_num1 = pc_i;
				dec_num2 = 32'd4;
				dec_jmp = (opcode == JAL) ? J_JAL : J_JALR;
				dec_base = (opcode == JAL) ? pc_i : rs1_val;
				dec_offset = (opcode == JAL) ? imm_j : imm_i;
				use_rs1 = opcode == JALR;
			end
			BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case (funct3)
					3'b000: dec_jmp = J_BEQ;
					3'b001: dec_jmp = J_BNE;
					3'b100: dec_jmp = J_BLT;
					3'b101: dec_jmp = J_BGE;
					3'b110: dec_jmp = J_BLTU;
					3'b111: dec_jmp = J_BGEU;
					default: dec_jmp = J_NONE;
				endcase
			end
			LOAD: begin
				use_rs1 = 1'b1;
				dec_num2 = imm_i;
				case (funct3)
					3'b000: dec_load = LB;
					3'b001: dec_load = LH;
					3'b010: dec_load = LW;
					3'b100: dec_load = LBU;
					3'b101: dec_load = LHU;
					default: dec_load = L_NONE;
				endcase
				dec_wr_en = dec_load != L_NONE;
			end
			STORE: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec_num2 = imm_s;
				case (funct3)
					3'b000: dec_store = SB;
					3'b001: dec_store = SH;
					3'b010: dec_store = SW;
					default: dec_store = S_NONE;
				endcase
			end
			OP_IMM: begin
				dec_wr_en = 1'b1;
				use_rs1 = 1'b1;
				dec_num2 = imm_i;
				dec_alu = alu_decode(funct3, instr_i[30], 1'b0);
			end
			OP: begin
				dec_wr_en = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec_alu = alu_decode(funct3, instr_i[30], 1'b1);
			end
			default: ; // unsupported opcodes pass as bubbles.
		endcase
	end

	// a hold or a taken jump sends a bubble into execute.
	assign issue = !jmp_en_i && hold_code_i != HOLD_IF;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			reg_wr_en_o <= 1'b0;
			load_code_o <= L_NONE;
			store_code_o <= S_NONE;
			jmp_flag_o <= J_NONE;
		end else begin
			reg_wr_en_o <= dec_wr_en && issue;
			load_code_o <= issue ? dec_load : L_NONE;
			store_code_o <= issue ? dec_store : S_NONE;
			jmp_flag_o <= issue ? dec_jmp : J_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_code_i != HOLD_IF) begin
			addr_wr_o <= instr_i[11:7];
			alu_operation_o <= dec_alu;
			alu_op_num1_o <= dec_num1;
			alu_op_num2_o <= dec_num2;
			store_data_o <= rs2_val;
			jmp_rs1_o <= rs1_val;
			jmp_rs2_o <= rs2_val;
			jmp_base_o <= dec_base;
			jmp_offset_o <= dec_offset;
		end
	end

	// a hold leaves a bubble in execute, so a load-use stall lasts one cycle.
	a_single_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		(load_hazard_o && !jmp_en_i) |=> !load_hazard_o);

endmodule

// ==== ex_stage/ex_stage.sv ====
/*
 * Execute stage: ALU, load/store lane formatting, data memory port and write-back select.
 */
`timescale 1ns/1ps

module ex_stage (
	input  rv_isa_pkg::load_code_e  load_code_i,
	input  rv_isa_pkg::store_code_e store_code_i,
	input  rv_isa_pkg::alu_op_e     alu_operation_i,
	input  rv_isa_pkg::data_t       alu_op_num1_i,
	input  rv_isa_pkg::data_t       alu_op_num2_i,
	input  rv_isa_pkg::data_t       store_data_i,
	input  rv_isa_pkg::reg_addr_t   addr_wr_i,
	input  logic                    reg_wr_en_i,
	input  rv_isa_pkg::data_t       data_mem_i,
	output rv_isa_pkg::data_t       alu_result_o,
	output logic                    is_load_o,
	output logic                    mem_state_o,
	output rv_isa_pkg::addr_t       addr_mem_o,
	output rv_isa_pkg::data_t       data_mem_wr_o,
	output logic [3:0]              mem_be_o,
	output logic                    reg_wr_en_o,
	output rv_isa_pkg::reg_addr_t   addr_reg_wr_o,
	output rv_isa_pkg::data_t       data_reg_wr_o
);
	import rv_isa_pkg::*;

	logic [4:0] shamt;
	logic [1:0] byte_off;
	data_t      rd_shift;
	data_t      load_val;

	assign shamt = alu_op_num2_i[4:0];

	always_comb begin
		case (alu_operation_i)
			ADD:    alu_result_o = alu_op_num1_i + alu_op_num2_i;
			SUB:    alu_result_o = alu_op_num1_i - alu_op_num2_i;
			SLL:    alu_result_o = alu_op_num1_i << shamt;
			SLT:    alu_result_o = {31'b0, $signed(alu_op_num1_i) < $signed(alu_op_num2_i)};
			SLTU:   alu_result_o = {31'b0, alu_op_num1_i < alu_op_num2_i};
			XOR:    alu_result_o = alu_op_num1_i ^ alu_op_num2_i;
			SRL:    alu_result_o = alu_op_num1_i >> shamt;
			SRA:    alu_result_o = data_t'($signed(alu_op_num1_i) >>> shamt);
			OR:     alu_result_o = alu_op_num1_i | alu_op_num2_i;
			AND:    alu_result_o = alu_op_num1_i & alu_op_num2_i;
			PASS_B: alu_result_o = alu_op_num2_i;
			default: alu_result_o = '0;
		endcase
	end

	assign addr_mem_o  = alu_result_o; // loads and stores address through the adder.
	assign byte_off    = alu_result_o[1:0];
	assign mem_state_o = store_code_i != S_NONE;

	always_comb begin
		case (store_code_i)
			SB: begin
				data_mem_wr_o = store_data_i << {byte_off, 3'b000};
				mem_be_o = 4'b0001 << byte_off;
			end
			SH: begin
				data_mem_wr_o = store_data_i << {byte_off[1], 4'b0000};
				mem_be_o = 4'b0011 << {byte_off[1], 1'b0};
			end
			SW: begin
				data_mem_wr_o = store_data_i;
				mem_be_o = 4'b1111;
			end
			default: begin
				data_mem_wr_o = store_data_i;
				mem_be_o = 4'b0000;
			end
		endcase
	end

	// move the addressed byte or halfword down to bit 0.
	assign rd_shift = data_mem_i >> {byte_off, 3'b000};

	always_comb begin
		case (load_code_i)
			LB:  load_val = {{24{rd_shift[7]}}, rd_shift[7:0]};
			LBU: load_val = {24'b0, rd_shift[7:0]};
			LH:  load_val = {{16{rd_shift[15]}}, rd_shift[15:0]};
			LHU: load_val = {16'b0, rd_shift[15:0]};
			default: load_val = data_mem_i;
		endcase
	end

	assign is_load_o     = load_code_i != L_NONE;
	assign reg_wr_en_o   = reg_wr_en_i;
	assign addr_reg_wr_o = addr_wr_i;
	assign data_reg_wr_o = is_load_o ? load_val : alu_result_o;

	// a store from decode never writes a register.
	a_store_state: assert final (!mem_state_o || !reg_wr_en_i);

endmodule

// ==== rtl/core.sv ====
/* RV32I pipeline core top level, wiring fetch, decode, execute, registers and control. */
`timescale 1ns/1ps

module core (
	input  logic              clk,
	input  logic              arst_n_i,
	input  rv_isa_pkg::data_t instr_i,
	input  rv_isa_pkg::data_t data_mem_i,
	output rv_isa_pkg::addr_t pc_o,
	output logic              instr_rd_en_o,
	output logic              mem_state_o,
	output rv_isa_pkg::addr_t addr_mem_o,
	output rv_isa_pkg::data_t data_mem_wr_o,
	output logic [3:0]        mem_be_o
);
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;

	hold_code_e  hold_code;
	logic        jmp_en;
	addr_t       jmp_to;
	reg_addr_t   addr_rs1, addr_rs2;
	data_t       data_rd1, data_rd2;

	reg_addr_t   id_addr_wr;
	logic        id_reg_wr_en;
	load_code_e  id_load_code;
	store_code_e id_store_code;
	alu_op_e     id_alu_operation;
	data_t       id_alu_op_num1, id_alu_op_num2, id_store_data;
	jmp_flag_e   id_jmp_flag;
	data_t       id_jmp_rs1, id_jmp_rs2, id_jmp_offset;
	addr_t       id_jmp_base;
	logic        load_hazard;

	data_t       ex_alu_result, ex_data_reg_wr;
	logic        ex_is_load, ex_reg_wr_en;
	reg_addr_t   ex_addr_reg_wr;

	pc core_pc (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.hold_code_i   (hold_code),
		.jmp_en_i      (jmp_en),
		.jmp_to_i      (jmp_to),
		.pc_o          (pc_o),
		.instr_rd_en_o (instr_rd_en_o)
	);

	id_stage core_id (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.hold_code_i     (hold_code),
		.jmp_en_i        (jmp_en),
		.instr_i         (instr_i),
		.pc_i            (pc_o),
		.data_rs1_i      (data_rd1),
		.data_rs2_i      (data_rd2),
		.ex_wr_en_i      (ex_reg_wr_en),
		.ex_addr_wr_i    (ex_addr_reg_wr),
		.ex_is_load_i    (ex_is_load),
		.ex_alu_result_i (ex_alu_result),
		.addr_rs1_o      (addr_rs1),
		.addr_rs2_o      (addr_rs2),
		.addr_wr_o       (id_addr_wr),
		.reg_wr_en_o     (id_reg_wr_en),
		.load_code_o     (id_load_code),
		.store_code_o    (id_store_code),
		.alu_operation_o (id_alu_operation),
		.alu_op_num1_o   (id_alu_op_num1),
		.alu_op_num2_o   (id_alu_op_num2),
		.store_data_o    (id_store_data),
		.jmp_flag_o      (id_jmp_flag),
		.jmp_rs1_o       (id_jmp_rs1),
		.jmp_rs2_o       (id_jmp_rs2),
		.jmp_base_o      (id_jmp_base),
		.jmp_offset_o    (id_jmp_offset),
		.load_hazard_o   (load_hazard)
	);

	ex_stage core_ex (
		.load_code_i     (id_load_code),
		.store_code_i    (id_store_code),
		.alu_operation_i (id_alu_operation),
		.alu_op_num1_i   (id_alu_op_num1),
		.alu_op_num2_i   (id_alu_op_num2),
		.store_data_i    (id_store_data),
		.addr_wr_i       (id_addr_wr),
		.reg_wr_en_i     (id_reg_wr_en),
		.data_mem_i      (data_mem_i),
		.alu_result_o    (ex_alu_result),
		.is_load_o       (ex_is_load),
		.mem_state_o     (mem_state_o),
		.addr_mem_o      (addr_mem_o),
		.data_mem_wr_o   (data_mem_wr_o),
		.mem_be_o        (mem_be_o),
		.reg_wr_en_o     (ex_reg_wr_en),
		.addr_reg_wr_o   (ex_addr_reg_wr),
		.data_reg_wr_o   (ex_data_reg_wr)
	);

	regs core_regs (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.wr_en_i    (ex_reg_wr_en),
		.addr_wr_i  (ex_addr_reg_wr),
		.addr_rd1_i (addr_rs1),
		.addr_rd2_i (addr_rs2),
		.data_wr_i  (ex_data_reg_wr),
		.data_rd1_o (data_rd1),
		.data_rd2_o (data_rd2)
	);

	ctrl core_ctrl (
		.jmp_flag_i    (id_jmp_flag),
		.jmp_rs1_i     (id_jmp_rs1),
		.jmp_rs2_i     (id_jmp_rs2),
		.jmp_base_i    (id_jmp_base),
		.jmp_offset_i  (id_jmp_offset),
		.load_hazard_i (load_hazard),
		.jmp_en_o      (jmp_en),
		.jmp_to_o      (jmp_to),
		.hold_code_o   (hold_code)
	);

endmodule

// ==== dv/tb_core.sv ====
/*
 * Testbench for the RV32I core: clock, reset, instruction and data memory models,
 * instruction encoders, compare tasks and directed tests.
 */
`timescale 1ns/1ps

module tb_core;
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;

	localparam data_t NOP      = 32'h0000_0013; // addi x0, x0, 0.
	localparam addr_t END_ADDR = 32'h0000_03fc;
	// five programs of under 100 instructions plus reset, with room for stalls.
	localparam int MAX_CYCLES = 4000;

	logic       clk;
	logic       arst_n_i;
	data_t      instr_i, data_mem_i, data_mem_wr_o;
	addr_t      pc_o, addr_mem_o;
	logic       instr_rd_en_o, mem_state_o;
	logic [3:0] mem_be_o;

	data_t imem [512];
	data_t dmem [256];
	int    wp;
	int    errors;
	int    cycles;
	logic [31:0] rng;
	addr_t exp_addr [$];
	data_t exp_val [$];

	core dut (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.instr_i       (instr_i),
		.data_mem_i    (data_mem_i),
		.pc_o          (pc_o),
		.instr_rd_en_o (instr_rd_en_o),
		.mem_state_o   (mem_state_o),
		.addr_mem_o    (addr_mem_o),
		.data_mem_wr_o (data_mem_wr_o),
		.mem_be_o      (mem_be_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// both memories answer in the same cycle.
	assign instr_i    = imem[pc_o[10:2]];
	assign data_mem_i = dmem[addr_mem_o[9:2]];

	always @(posedge clk) begin
		if (mem_state_o) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_be_o[i]) dmem[addr_mem_o[9:2]][8*i +: 8] <= data_mem_wr_o[8*i +: 8];
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: no end-marker store after %0d cycles", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	function automatic data_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
			logic [2:0] f3, reg_addr_t rd, opcode_e op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic data_t enc_i(data_t imm, reg_addr_t rs1, logic [2:0] f3,
			reg_addr_t rd, opcode_e op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic data_t enc_s(data_t imm, reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
	endfunction

	function automatic data_t enc_b(data_t imm, reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
	endfunction

	function automatic data_t enc_j(data_t imm, reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
	endfunction

	// expected ALU result from the RV32I rules.
	function automatic data_t alu_model(logic [2:0] f3, logic alt, data_t a, data_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(logic [2:0] f3, data_t a, data_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_data(string name, data_t exp, data_t act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(string name, addr_t exp, addr_t act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic emit(data_t ins);
		imem[wp] = ins;
		wp++;
	endtask

	task automatic load_imm(reg_addr_t rd, data_t v);
		data_t lo;
		lo = {{20{v[11]}}, v[11:0]};
		emit({v[31:12] - lo[31:12], rd, LUI}); // upper part absorbs the addi sign.
		emit(enc_i(v, rd, 3'd0, rd, OP_IMM));
	endtask

	task automatic store_expect(reg_addr_t rs, addr_t a, data_t v);
		emit(enc_s(a, rs, 5'd0, 3'd2));
		exp_addr.push_back(a);
		exp_val.push_back(v);
	endtask

	task automatic new_program();
		for (int i = 0; i < 512; i++) imem[i] = NOP;
		for (int i = 0; i < 256; i++) dmem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000;
		wp = 0;
		exp_addr.delete();
		exp_val.delete();
	endtask

	task automatic reset_core();
		@(posedge clk);
		arst_n_i <= 1'b0;
		repeat (10) @(posedge clk);
		arst_n_i <= 1'b1;
	endtask

	// runs until the end-marker store has landed, counting cycles with fetch held.
	task automatic run_program(output int low, output int max_run);
		int run;
		logic done;
		emit(enc_s(END_ADDR, 5'd0, 5'd0, 3'd2));
		reset_core();
		low = 0;
		run = 0;
		max_run = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (!instr_rd_en_o) begin
				low++;
				run++;
				if (run > max_run) max_run = run;
			end else begin
				run = 0;
			end
			done = mem_state_o && addr_mem_o == END_ADDR;
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < exp_addr.size(); i++)
			check_data($sformatf("mem[%h]", exp_addr[i]), exp_val[i], dmem[exp_addr[i][9:2]]);
	endtask

	task automatic test_reset();
		addr_t prev;
		new_program();
		reset_core();
		@(negedge clk);
		check_addr("pc_o", RESET_PC, pc_o);
		check_bit("mem_state_o", 1'b0, mem_state_o);
		check_bit("instr_rd_en_o", 1'b1, instr_rd_en_o);
		repeat (4) begin
			prev = pc_o;
			@(negedge clk);
			check_addr("pc_o", prev + 32'd4, pc_o);
		end
	endtask

	task automatic test_alu();
		data_t a, b, imm;
		logic [2:0] f3;
		int low, max_run;
		new_program();
		a = xorshift();
		b = xorshift();
		load_imm(5'd1, a);
		load_imm(5'd2, b);
		for (int k = 0; k < 10; k++) begin
			f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5); // last two are SUB and SRA.
			emit(enc_r((k >= 8) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3, OP));
			store_expect(5'd3, 32'h100 + 4 * k, alu_model(f3, k >= 8, a, b));
		end
		for (int k = 0; k < 9; k++) begin
			f3 = (k < 8) ? 3'(k) : 3'd5;
			imm = xorshift();
			imm = {{20{imm[11]}}, imm[11:0]};
			if (f3 == 3'd1 || f3 == 3'd5) imm = {20'b0, (k == 8) ? 7'h20 : 7'h00, imm[4:0]};
			emit(enc_i(imm, 5'd1, f3, 5'd3, OP_IMM));
			store_expect(5'd3, 32'h140 + 4 * k, alu_model(f3, k == 8, a, imm));
		end
		run_program(low, max_run);
	endtask

	task automatic test_bypass();
		data_t sum, k;
		int low, max_run;
		new_program();
		k = xorshift();
		sum = {21'b0, k[10:0]};
		emit(enc_i(sum, 5'd0, 3'd0, 5'd1, OP_IMM));
		repeat (8) begin
			k = xorshift();
			k = {{20{k[11]}}, k[11:0]};
			emit(enc_i(k, 5'd1, 3'd0, 5'd1, OP_IMM));
			sum = sum + k;
		end
		emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2, OP));
		store_expect(5'd2, 32'h180, sum + sum);
		run_program(low, max_run);
		check_data("instr_rd_en_o low cycles", 32'd0, data_t'(low));
	endtask

	task automatic test_load_store();
		data_t w, v, r;
		int low, max_run, n;
		new_program();
		w = xorshift() | 32'h0080_8000; // bytes 1 and 2 negative.
		load_imm(5'd1, w);
		store_expect(5'd1, 32'h200, w);
		for (int off = 0; off < 4; off++) begin
			v = xorshift();
			load_imm(5'd2, v);
			emit(enc_s(32'h208 + off, 5'd2, 5'd0, 3'd0));
			r[8*off +: 8] = v[7:0];
		end
		exp_addr.push_back(32'h208);
		exp_val.push_back(r);
		for (int off = 0; off < 4; off += 2) begin
			v = xorshift();
			load_imm(5'd2, v);
			emit(enc_s(32'h20c + off, 5'd2, 5'd0, 3'd1));
			r[8*off +: 16] = v[15:0];
		end
		exp_addr.push_back(32'h20c);
		exp_val.push_back(r);
		n = 0;
		for (int off = 0; off < 4; off++) begin
			v = w >> (8 * off);
			emit(enc_i(32'h200 + off, 5'd0, 3'd0, 5'd3, LOAD));
			store_expect(5'd3, 32'h220 + 4 * n, {{24{v[7]}}, v[7:0]});
			n++;
			emit(enc_i(32'h200 + off, 5'd0, 3'd4, 5'd3, LOAD));
			store_expect(5'd3, 32'h220 + 4 * n, {24'b0, v[7:0]});
			n++;
		end
		for (int off = 0; off < 4; off += 2) begin
			v = w >> (8 * off);
			emit(enc_i(32'h200 + off, 5'd0, 3'd1, 5'd3, LOAD));
			store_expect(5'd3, 32'h220 + 4 * n, {{16{v[15]}}, v[15:0]});
			n++;
			emit(enc_i(32'h200 + off, 5'd0, 3'd5, 5'd3, LOAD));
			store_expect(5'd3, 32'h220 + 4 * n, {16'b0, v[15:0]});
			n++;
		end
		emit(enc_i(32'h200, 5'd0, 3'd2, 5'd3, LOAD));
		store_expect(5'd3, 32'h220 + 4 * n, w);
		n++;
		run_program(low, max_run);
		// every load above is used at once, one held cycle each.
		check_data("instr_rd_en_o low cycles", data_t'(n), data_t'(low));
		check_data("longest fetch hold", 32'd1, data_t'(max_run));
	endtask

	task automatic test_control();
		logic [2:0] f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
		reg_addr_t  r1s [12] = '{1, 1, 1, 1, 1, 2, 2, 1, 2, 1, 1, 2};
		reg_addr_t  r2s [12] = '{1, 2, 2, 1, 2, 1, 1, 2, 1, 2, 2, 1};
		data_t a, b, t;
		int low, max_run;
		new_program();
		emit(enc_i(32'hfff, 5'd0, 3'd0, 5'd1, OP_IMM)); // x1 = -1.
		emit(enc_i(32'd1, 5'd0, 3'd0, 5'd2, OP_IMM));
		emit(enc_i(32'd0, 5'd0, 3'd0, 5'd7, OP_IMM));
		for (int k = 0; k < 12; k++) begin
			a = (r1s[k] == 5'd1) ? 32'hffff_ffff : 32'd1;
			b = (r2s[k] == 5'd1) ? 32'hffff_ffff : 32'd1;
			emit(enc_i(32'd0, 5'd0, 3'd0, 5'd4, OP_IMM));
			emit(enc_b(32'd8, r2s[k], r1s[k], f3s[k]));
			emit(enc_i(32'd1, 5'd0, 3'd0, 5'd4, OP_IMM)); // skipped when taken.
			store_expect(5'd4, 32'h280 + 4 * k, {31'b0, !branch_model(f3s[k], a, b)});
		end
		t = 4 * wp + 4;
		emit(enc_j(32'd8, 5'd6));
		emit(enc_i(32'd1, 5'd0, 3'd0, 5'd7, OP_IMM));
		store_expect(5'd6, 32'h2c0, t);
		t = 4 * (wp + 3);
		emit(enc_i(t, 5'd0, 3'd0, 5'd9, OP_IMM));
		emit(enc_i(32'd1, 5'd9, 3'd0, 5'd8, JALR)); // target bit 0 is dropped.
		emit(enc_i(32'd1, 5'd0, 3'd0, 5'd7, OP_IMM));
		store_expect(5'd8, 32'h2c4, t - 32'd4);
		store_expect(5'd7, 32'h2c8, 32'd0);
		run_program(low, max_run);
	endtask

	initial begin
		arst_n_i = 1'b0;
		errors = 0;
		cycles = 0;
		rng = 32'hc072;
		test_reset();
		test_alu();
		test_bypass();
		test_load_store();
		test_control();
		$display("errors: %0d, cycles: %0d", errors, cycles);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== ecnu_core.f ====
common/rv_isa_pkg.sv
common/pipe_ctrl_pkg.sv
rtl/pc.sv
rtl/regs.sv
rtl/ctrl.sv
id_stage/id_stage.sv
ex_stage/ex_stage.sv
rtl/core.sv
dv/tb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the core and its testbench with Verilator, run, and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f ecnu_core.f -o vtb_core
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/vtb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0
